// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - files:
      - hw/fetch_pkg.sv
      - hw/predecode.sv
      - hw/fetch_request_ctrl.sv
      - hw/strand_fetch_unit.sv
      - hw/strand_select.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - bench/fetch_tb.sv

// File: bench/fetch_tb.sv
/*
 Testbench for fetch_top with a one-cycle cache model. Memory holds 1024 words
 and every address wraps on bits 11:2. Rollback is only driven while issue stalls.
*/
`timescale 1ns/1ns

module fetch_tb
	import fetch_pkg::*;
();

	localparam int num_strands = 4;
	localparam int mem_words = 1024;
	localparam int target_issues = 400;
	// Stall window for the back-pressure test in cycles after reset
	localparam int stall_start = 150;
	localparam int stall_len = 30;
	// Roughly 1000 cycles for 400 issues at the random ready rate plus a wide margin
	localparam int max_cycles = 20000;

	// Expected issue entry plus where the strand goes next
	typedef struct packed
	{
		fetch_entry_t entry;
		logic [31:0]  next_pc;
	} expect_t;

	logic clk;
	logic reset;
	logic icache_request;
	logic [31:0] icache_addr;
	logic [1:0] icache_strand;
	logic icache_hit;
	logic icache_collision;
	logic [31:0] icache_data;
	logic [num_strands-1:0] load_done;
	logic [num_strands-1:0] rollback;
	logic [num_strands-1:0][31:0] rollback_pc;
	logic issue_ready;
	logic issue_valid;
	logic [1:0] issue_strand;
	fetch_entry_t issue_entry;

	// Cache contents stored little-endian
	logic [31:0] mem [mem_words];
	logic [31:0] exp_pc [num_strands];
	// Fetch-side pc per strand, moved on each hit and on rollback
	logic [31:0] fetch_pc [num_strands];
	int unsigned load_cnt [num_strands];
	// Request seen at the last rising edge and answered in the next cycle
	logic req_pending;
	logic [31:0] req_addr;
	logic [1:0] req_strand;
	logic seen_hit;
	int unsigned issued;
	int unsigned cycles;

	fetch_top #(.NUM_STRANDS(num_strands), .FIFO_DEPTH(4)) dut0
	(
		.clk(clk),
		.reset(reset),
		.icache_request_o(icache_request),
		.icache_addr_o(icache_addr),
		.icache_strand_o(icache_strand),
		.icache_hit_i(icache_hit),
		.icache_collision_i(icache_collision),
		.icache_data_i(icache_data),
		.icache_load_done_i(load_done),
		.rollback_i(rollback),
		.rollback_pc_i(rollback_pc),
		.issue_ready_i(issue_ready),
		.issue_valid_o(issue_valid),
		.issue_strand_o(issue_strand),
		.issue_entry_o(issue_entry)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Big-endian instruction for word idx with branch targets inside memory
	function automatic logic [31:0] make_instruction(input int idx);
		logic [31:0] ins;
		branch_kind_e kind;
		int sel;
		int target;
		int offset;
		ins = $urandom();
		sel = $urandom_range(15, 0);
		target = -1;
		// Plain words never fall in the control class
		if (ins[31:28] == 4'hf)
			ins[28] = 1'b0;
		if (sel == 0 && idx < mem_words - 1)
			target = $urandom_range(mem_words - 1, idx + 1);
		else if (sel == 1)
			target = $urandom_range(idx, 0);
		else if (sel == 2 || sel == 3)
			target = $urandom_range(mem_words - 1, 0);
		if (sel == 2)
			kind = br_call;
		else if (sel == 3)
			kind = br_always;
		else
			case ($urandom_range(3, 0))
				0: kind = br_cond_zero;
				1: kind = br_cond_nonzero;
				2: kind = br_cond_all;
				default: kind = br_cond_neg;
			endcase
		if (target >= 0)
		begin
			// Offset counts bytes from the following instruction
			offset = (target - idx - 1) * 4;
			ins[31:28] = 4'hf;
			ins[27:25] = kind;
			ins[24:5] = offset[19:0];
		end
		// Format A multiply
		if (sel == 4)
		begin
			ins[31:29] = 3'b110;
			ins[25:20] = 6'h07;
		end
		// Format B multiply with its 5-bit opcode field
		if (sel == 5)
		begin
			ins[31] = 1'b0;
			ins[27:23] = 5'h07;
		end
		return ins;
	endfunction

	// Expected result of fetching word at pc
	function automatic expect_t ref_fetch(input logic [31:0] pc, input logic [31:0] word);
		expect_t e;
		logic [31:0] ins;
		logic [31:0] offset;
		logic [2:0] kind;
		logic is_ctrl;
		logic is_cond;
		ins = swap_bytes(word);
		offset = {{12{ins[24]}}, ins[24:5]};
		kind = ins[27:25];
		is_ctrl = (ins[31:28] == 4'hf);
		is_cond = is_ctrl && (kind == br_cond_zero || kind == br_cond_nonzero
			|| kind == br_cond_all || kind == br_cond_neg);
		e.entry.pc = pc + 32'd4;
		e.entry.instruction = ins;
		// Unconditional taken always and conditional only when backward
		e.entry.branch_predicted = (is_ctrl && (kind == br_always || kind == br_call))
			|| (is_cond && offset[31]);
		// Float ops in format A and multiply in either format
		e.entry.long_latency = (ins[31:29] == 3'b110 && (ins[25] || ins[25:20] == 6'h07))
			|| (!ins[31] && ins[27:23] == 5'h07);
		e.next_pc = e.entry.branch_predicted ? pc + 32'd4 + offset : pc + 32'd4;
		return e;
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
		input string what);
		if (got !== want)
		begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clk)
	begin
		req_pending = icache_request;
		req_addr = icache_addr;
		req_strand = icache_strand;
	end

	// Drives cache answers, load_done pulses, ready and rollback on the falling edge
	initial
	begin : stimulus
		int unsigned r;
		int s;
		int unsigned cycle;
		expect_t resp;
		void'($urandom(51757));
		clk = 1'b0;
		reset = 1'b1;
		icache_hit = 1'b0;
		icache_collision = 1'b0;
		icache_data = '0;
		load_done = '0;
		rollback = '0;
		rollback_pc = '0;
		issue_ready = 1'b0;
		for (int i = 0; i < mem_words; i++)
			mem[i] = swap_bytes(make_instruction(i));
		for (int i = 0; i < num_strands; i++)
		begin
			exp_pc[i] = '0;
			fetch_pc[i] = '0;
			load_cnt[i] = 0;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		cycle = 0;
		forever
		begin
			@(negedge clk);
			cycle++;
			load_done = '0;
			for (int i = 0; i < num_strands; i++)
				if (load_cnt[i] != 0)
				begin
					load_cnt[i]--;
					if (load_cnt[i] == 0)
						load_done[i] = 1'b1;
				end
			icache_hit = 1'b0;
			icache_collision = 1'b0;
			icache_data = '0;
			// 70 percent hit, 10 collision and 20 miss
			if (req_pending)
			begin
				// Requester must ask for the word its fetch walk has reached
				check_equal(req_addr, fetch_pc[req_strand],
					$sformatf("strand %0d fetch address", req_strand));
				r = $urandom_range(99, 0);
				if (r < 70)
				begin
					icache_hit = 1'b1;
					icache_data = mem[req_addr[11:2]];
					resp = ref_fetch(req_addr, icache_data);
					fetch_pc[req_strand] = resp.next_pc;
				end
				else if (r < 80)
					icache_collision = 1'b1;
				else
					load_cnt[req_strand] = $urandom_range(8, 2);
			end
			rollback = '0;
			if (cycle >= stall_start && cycle < stall_start + stall_len)
				issue_ready = 1'b0;
			else
			begin
				issue_ready = ($urandom_range(3, 0) != 0);
				if (!issue_ready && $urandom_range(9, 0) == 0)
				begin
					s = $urandom_range(num_strands - 1, 0);
					rollback[s] = 1'b1;
					rollback_pc[s] = 32'($urandom_range(mem_words - 1, 0)) << 2;
					exp_pc[s] = rollback_pc[s];
					fetch_pc[s] = rollback_pc[s];
				end
			end
		end
	end

	// Checks every issued instruction against the reference walk
	initial
	begin : compare
		expect_t want;
		int s;
		issued = 0;
		seen_hit = 1'b0;
		@(negedge reset);
		while (issued < target_issues)
		begin
			@(posedge clk);
			if (issue_valid && !seen_hit)
			begin
				$display("Error: issue_valid_o went high at %0t ns before any cache hit", $time);
				$display("CHECKS FAILED");
				$fatal(1, "early issue");
			end
			if (icache_hit)
				seen_hit = 1'b1;
			if (issue_valid && issue_ready)
			begin
				s = issue_strand;
				want = ref_fetch(exp_pc[s], mem[exp_pc[s][11:2]]);
				check_equal(issue_entry.instruction, want.entry.instruction,
					$sformatf("strand %0d instruction", s));
				check_equal(issue_entry.pc, want.entry.pc, $sformatf("strand %0d pc", s));
				check_equal(32'(issue_entry.branch_predicted), 32'(want.entry.branch_predicted),
					$sformatf("strand %0d branch_predicted", s));
				check_equal(32'(issue_entry.long_latency), 32'(want.entry.long_latency),
					$sformatf("strand %0d long_latency", s));
				exp_pc[s] = want.next_pc;
				issued++;
			end
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial
	begin : watchdog
		cycles = 0;
		while (cycles < max_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: fewer than %0d instructions issued in %0d cycles",
			target_issues, max_cycles);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

endmodule

// File: hw/fetch_pkg.sv
/*
 Shared types for the instruction fetch path. Instruction words are big-endian
 after the byte swap. Format B carries only a 5-bit integer opcode field.
*/
package fetch_pkg;

	// Byte distance between consecutive instructions
	localparam logic [31:0] pc_step = 32'd4;

	// Instruction class taken from the top bits of the swapped word
	typedef enum logic [2:0]
	{
		fmt_b     = 3'b000,
		fmt_other = 3'b100,
		fmt_a     = 3'b110,
		fmt_ctrl  = 3'b111
	} fmt_e;

	// Subcode in bits 27:25 of a control-class word
	typedef enum logic [2:0]
	{
		br_cond_zero    = 3'b000,
		br_cond_nonzero = 3'b001,
		br_cond_all     = 3'b010,
		br_always       = 3'b011,
		br_call         = 3'b100,
		br_cond_neg     = 3'b101
	} branch_kind_e;

	// Arithmetic opcodes, top bit set means floating point
	typedef enum logic [5:0]
	{
		op_or   = 6'h00,
		op_and  = 6'h01,
		op_xor  = 6'h03,
		op_iadd = 6'h05,
		op_isub = 6'h06,
		op_imul = 6'h07,
		op_fadd = 6'h20,
		op_fsub = 6'h21,
		op_fmul = 6'h22
	} arith_op_e;

	// Result of pre-decoding one cache word
	typedef struct packed
	{
		logic [31:0] instruction;
		logic [31:0] branch_offset;
		logic        branch_predicted;
		logic        long_latency;
	} predecode_t;

	// One FIFO slot, pc is the address of the following instruction
	typedef struct packed
	{
		logic [31:0] pc;
		logic [31:0] instruction;
		logic        branch_predicted;
		logic        long_latency;
	} fetch_entry_t;

endpackage

// File: hw/fetch_request_ctrl.sv
/*
 Assumes the cache answers exactly one cycle after each request strobe.
 A missing strand stays parked until its load_done bit pulses.
*/
`timescale 1ns/1ns

module fetch_request_ctrl import fetch_pkg::*;
#(
	parameter int NUM_STRANDS = 4
)
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic [NUM_STRANDS-1:0]        can_request_i,
	input  logic [NUM_STRANDS-1:0][31:0]  next_pc_i,
	input  logic                          icache_hit_i,
	input  logic                          icache_collision_i,
	input  logic [31:0]                   icache_data_i,
	input  logic [NUM_STRANDS-1:0]        icache_load_done_i,
	output logic                          icache_request_o,
	output logic [31:0]                   icache_addr_o,
	output logic [$clog2(NUM_STRANDS)-1:0] icache_strand_o,
	output logic [NUM_STRANDS-1:0]        enqueue_o,
	output predecode_t                    resp_entry_o
);

	localparam int IDX_W = $clog2(NUM_STRANDS);

	logic [NUM_STRANDS-1:0] wait_q;
	logic [NUM_STRANDS-1:0] wait_nxt;
	// One-hot owner of the response arriving this cycle
	logic [NUM_STRANDS-1:0] last_req_q;
	logic [NUM_STRANDS-1:0] eligible;
	logic [NUM_STRANDS-1:0] grant_oh;
	logic [IDX_W-1:0] grant_idx;
	logic [IDX_W-1:0] prio_q;
	logic granted;

	predecode u_predecode
	(
		.cache_word_i(icache_data_i),
		.decoded_o(resp_entry_o)
	);

	// Miss parks the last requester, finished loads release strands
	always_comb
	begin
		wait_nxt = wait_q & ~icache_load_done_i;
		if (!icache_hit_i && !icache_collision_i)
			wait_nxt = wait_nxt | last_req_q;
	end

	assign eligible = can_request_i & ~wait_nxt;

	// Rotating priority, search starts at prio_q
	always_comb
	begin
		int unsigned cand;
		granted = 1'b0;
		grant_idx = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			cand = prio_q + i;
			if (cand >= NUM_STRANDS)
				cand = cand - NUM_STRANDS;
			if (!granted && eligible[cand])
			begin
				granted = 1'b1;
				grant_idx = IDX_W'(cand);
			end
		end
		grant_oh = granted ? (NUM_STRANDS'(1) << grant_idx) : '0;
	end

	assign icache_request_o = granted;
	assign icache_strand_o = grant_idx;
	// Address is the resolved next pc of the winner
	assign icache_addr_o = next_pc_i[grant_idx];

	// Only the strand that asked last cycle may take the data
	assign enqueue_o = last_req_q & {NUM_STRANDS{icache_hit_i}};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wait_q <= '0;
			last_req_q <= '0;
			prio_q <= '0;
		end
		else
		begin
			wait_q <= wait_nxt;
			last_req_q <= grant_oh;
			// Winner drops to lowest priority
			if (granted)
				prio_q <= (grant_idx == IDX_W'(NUM_STRANDS - 1)) ? '0 : grant_idx + 1'b1;
		end
	end

endmodule

// File: hw/fetch_top.sv
/*
 Fetch subsystem top level. The instruction cache sits outside and must
 answer each request strobe on the next cycle.
*/
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*;
#(
	parameter int NUM_STRANDS = 4,
	parameter int FIFO_DEPTH  = 4
)
(
	input  logic                           clk,
	input  logic                           reset,
	output logic                           icache_request_o,
	output logic [31:0]                    icache_addr_o,
	output logic [$clog2(NUM_STRANDS)-1:0] icache_strand_o,
	input  logic                           icache_hit_i,
	input  logic                           icache_collision_i,
	input  logic [31:0]                    icache_data_i,
	input  logic [NUM_STRANDS-1:0]         icache_load_done_i,
	input  logic [NUM_STRANDS-1:0]         rollback_i,
	input  logic [NUM_STRANDS-1:0][31:0]   rollback_pc_i,
	input  logic                           issue_ready_i,
	output logic                           issue_valid_o,
	output logic [$clog2(NUM_STRANDS)-1:0] issue_strand_o,
	output fetch_entry_t                   issue_entry_o
);

	logic [NUM_STRANDS-1:0] can_request;
	logic [NUM_STRANDS-1:0][31:0] next_pc;
	logic [NUM_STRANDS-1:0] enqueue;
	logic [NUM_STRANDS-1:0] fifo_valid;
	logic [NUM_STRANDS-1:0] dequeue;
	fetch_entry_t [NUM_STRANDS-1:0] heads;
	// Response broadcast to all strands, enqueue picks the owner
	predecode_t resp_entry;

	fetch_request_ctrl #(.NUM_STRANDS(NUM_STRANDS)) u_request_ctrl
	(
		.clk(clk),
		.reset(reset),
		.can_request_i(can_request),
		.next_pc_i(next_pc),
		.icache_hit_i(icache_hit_i),
		.icache_collision_i(icache_collision_i),
		.icache_data_i(icache_data_i),
		.icache_load_done_i(icache_load_done_i),
		.icache_request_o(icache_request_o),
		.icache_addr_o(icache_addr_o),
		.icache_strand_o(icache_strand_o),
		.enqueue_o(enqueue),
		.resp_entry_o(resp_entry)
	);

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : strand
		strand_fetch_unit #(.FIFO_DEPTH(FIFO_DEPTH)) u_unit
		(
			.clk(clk),
			.reset(reset),
			.enqueue_i(enqueue[s]),
			.rollback_i(rollback_i[s]),
			.rollback_pc_i(rollback_pc_i[s]),
			.resp_i(resp_entry),
			.dequeue_i(dequeue[s]),
			.can_request_o(can_request[s]),
			.next_pc_o(next_pc[s]),
			.fifo_valid_o(fifo_valid[s]),
			.head_o(heads[s])
		);
	end

	strand_select #(.NUM_STRANDS(NUM_STRANDS)) u_select
	(
		.clk(clk),
		.reset(reset),
		.fifo_valid_i(fifo_valid),
		.heads_i(heads),
		.issue_ready_i(issue_ready_i),
		.dequeue_o(dequeue),
		.issue_valid_o(issue_valid_o),
		.issue_strand_o(issue_strand_o),
		.issue_entry_o(issue_entry_o)
	);

endmodule

// File: hw/predecode.sv
/*
 Purely combinational. Static prediction only: backward conditional branches,
 branch-always and calls are predicted taken.
*/
`timescale 1ns/1ns

module predecode import fetch_pkg::*;
(
	input  logic [31:0] cache_word_i,
	output predecode_t  decoded_o
);

	logic [31:0] swapped;
	logic [31:0] offset;
	fmt_e fmt;
	branch_kind_e kind;
	arith_op_e op_a;
	arith_op_e op_b;
	logic is_cond;

	// Cache delivers little-endian words
	assign swapped = {cache_word_i[7:0], cache_word_i[15:8],
		cache_word_i[23:16], cache_word_i[31:24]};

	// 20-bit signed offset sits in bits 24:5
	assign offset = {{12{swapped[24]}}, swapped[24:5]};

	assign kind = branch_kind_e'(swapped[27:25]);
	assign op_a = arith_op_e'(swapped[25:20]);
	// Format B opcode field is one bit short, integer ops only
	assign op_b = arith_op_e'({1'b0, swapped[27:23]});

	always_comb
	begin
		if (!swapped[31])
			fmt = fmt_b;
		else if (swapped[31:29] == 3'b110)
			fmt = fmt_a;
		else if (swapped[31:28] == 4'b1111)
			fmt = fmt_ctrl;
		else
			fmt = fmt_other;
	end

	assign is_cond = (fmt == fmt_ctrl) && (kind == br_cond_zero || kind == br_cond_nonzero
		|| kind == br_cond_all || kind == br_cond_neg);

	assign decoded_o.instruction = swapped;
	assign decoded_o.branch_offset = offset;

	// Taken when unconditional, or conditional and jumping backward
	assign decoded_o.branch_predicted = ((fmt == fmt_ctrl)
		&& (kind == br_always || kind == br_call)) || (is_cond && offset[31]);

	// Float ops and multiplies go to the long pipeline
	assign decoded_o.long_latency = ((fmt == fmt_a) && (op_a[5] || op_a == op_imul))
		|| ((fmt == fmt_b) && op_b == op_imul);

endmodule

// File: hw/strand_fetch_unit.sv
/*
 One strand: program counter plus instruction FIFO. Rollback flushes the FIFO
 and wins over a same-cycle enqueue. Dequeue is ignored while empty.
*/
`timescale 1ns/1ns

module strand_fetch_unit import fetch_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic         clk,
	input  logic         reset,
	input  logic         enqueue_i,
	input  logic         rollback_i,
	input  logic [31:0]  rollback_pc_i,
	input  predecode_t   resp_i,
	input  logic         dequeue_i,
	output logic         can_request_o,
	output logic [31:0]  next_pc_o,
	output logic         fifo_valid_o,
	output fetch_entry_t head_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	fetch_entry_t mem [FIFO_DEPTH];
	fetch_entry_t new_entry;
	logic [31:0] pc_q;
	logic [31:0] next_pc;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic almost_full;
	logic do_enq;
	logic do_deq;

	// Wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// pc_q still points at the word being returned
	always_comb
	begin
		if (rollback_i)
			next_pc = rollback_pc_i;
		else if (!enqueue_i)
			next_pc = pc_q;
		else if (resp_i.branch_predicted)
			next_pc = pc_q + pc_step + resp_i.branch_offset;
		else
			next_pc = pc_q + pc_step;
	end

	assign next_pc_o = next_pc;

	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign almost_full = (count == CNT_W'(FIFO_DEPTH - 1));
	// Leave room for the response already in flight
	assign can_request_o = !full && !(almost_full && enqueue_i);

	assign fifo_valid_o = (count != '0);
	assign head_o = mem[rd_ptr];

	assign do_enq = enqueue_i && !rollback_i && !full;
	assign do_deq = dequeue_i && fifo_valid_o && !rollback_i;

	assign new_entry.pc = pc_q + pc_step;
	assign new_entry.instruction = resp_i.instruction;
	assign new_entry.branch_predicted = resp_i.branch_predicted;
	assign new_entry.long_latency = resp_i.long_latency;

	always_ff @(posedge clk)
	begin
		if (do_enq)
			mem[wr_ptr] <= new_entry;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pc_q <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			pc_q <= next_pc;
			if (rollback_i)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else
			begin
				if (do_enq)
					wr_ptr <= ptr_inc(wr_ptr);
				if (do_deq)
					rd_ptr <= ptr_inc(rd_ptr);
				if (do_enq && !do_deq)
					count <= count + 1'b1;
				else if (do_deq && !do_enq)
					count <= count - 1'b1;
			end
		end
	end

endmodule

// File: hw/strand_select.sv
/*
 Combinational from FIFO heads to issue outputs. The dequeue takes effect at
 the clock edge, and only while issue_ready_i is high.
*/
`timescale 1ns/1ns

module strand_select import fetch_pkg::*;
#(
	parameter int NUM_STRANDS = 4
)
(
	input  logic                           clk,
	input  logic                           reset,
	input  logic [NUM_STRANDS-1:0]         fifo_valid_i,
	input  fetch_entry_t [NUM_STRANDS-1:0] heads_i,
	input  logic                           issue_ready_i,
	output logic [NUM_STRANDS-1:0]         dequeue_o,
	output logic                           issue_valid_o,
	output logic [$clog2(NUM_STRANDS)-1:0] issue_strand_o,
	output fetch_entry_t                   issue_entry_o
);

	localparam int IDX_W = $clog2(NUM_STRANDS);

	logic [IDX_W-1:0] ptr_q;
	logic [IDX_W-1:0] pick;
	logic found;

	// First valid strand at or after the pointer
	always_comb
	begin
		int unsigned cand;
		found = 1'b0;
		pick = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			cand = ptr_q + i;
			if (cand >= NUM_STRANDS)
				cand = cand - NUM_STRANDS;
			if (!found && fifo_valid_i[cand])
			begin
				found = 1'b1;
				pick = IDX_W'(cand);
			end
		end
	end

	assign issue_valid_o = found;
	assign issue_strand_o = pick;
	assign issue_entry_o = heads_i[pick];
	assign dequeue_o = (found && issue_ready_i) ? (NUM_STRANDS'(1) << pick) : '0;

	// Move past the strand just issued
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ptr_q <= '0;
		else if (found && issue_ready_i)
			ptr_q <= (pick == IDX_W'(NUM_STRANDS - 1)) ? '0 : pick + 1'b1;
	end

endmodule

// File: src.f
hw/fetch_pkg.sv
hw/predecode.sv
hw/fetch_request_ctrl.sv
hw/strand_fetch_unit.sv
hw/strand_select.sv
hw/fetch_top.sv
bench/fetch_tb.sv
